// File: hdl/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath and address width
`define RV_XLEN       32
`define RV_RESET_PC   32'h0000_0000

// major opcodes, inst[6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_SYSTEM  7'b1110011

// branch conditions
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111

// alu operations, shared by OP and OP-IMM
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// jalr and word access
`define RV_F3_JALR    3'b000
`define RV_F3_WORD    3'b010

// funct7 values; ALT selects sub and sra
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`define RV_EBREAK     32'h0010_0073

`endif

// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

	// alu operation chosen by the decoder
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// source of the register writeback value
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_LOAD = 2'd1,
		WB_LINK = 2'd2
	} wb_sel_e;

	// redirect condition, JUMP is unconditional
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6,
		BR_JUMP = 3'd7
	} br_cond_e;

endpackage

// File: hdl/rv_pc_counter.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_pc_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                redirect_i,
	input  logic [`RV_XLEN-1:0] target_i,
	input  logic                stop_i,
	output logic [`RV_XLEN-1:0] pc_o,
	output logic                halt_o
);

	logic [`RV_XLEN-1:0] pc_q;
	logic [`RV_XLEN-1:0] next_pc;
	logic                halt_q;

	// taken branch or jump wins over sequential fetch
	assign next_pc = redirect_i ? target_i : pc_q + `RV_XLEN'd4;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_q   <= `RV_RESET_PC;
			halt_q <= 1'b0;
		end else begin
			if (stop_i) begin
				halt_q <= 1'b1;
			end
			// pc stays on the stop instruction
			if (!(stop_i || halt_q)) begin
				pc_q <= next_pc;
			end
		end
	end

	assign pc_o   = pc_q;
	assign halt_o = halt_q;

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic                we_i,
	input  logic [4:0]          waddr_i,
	input  logic [`RV_XLEN-1:0] wdata_i,
	input  logic [4:0]          raddr1_i,
	input  logic [4:0]          raddr2_i,
	output logic [`RV_XLEN-1:0] rdata1_o,
	output logic [`RV_XLEN-1:0] rdata2_o
);

	logic [`RV_XLEN-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != 5'd0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 is hard-wired, reads never see the array
	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]    inst_i,
	input  logic                   halted_i,
	output logic [4:0]             rs1_o,
	output logic [4:0]             rs2_o,
	output logic [`RV_XLEN-1:0]    imm_o,
	output rv_core_pkg::alu_op_e   alu_op_o,
	output logic                   src_a_pc_o,
	output logic                   src_b_imm_o,
	output rv_core_pkg::wb_sel_e   wb_sel_o,
	output logic                   rd_we_o,
	output logic [4:0]             rd_o,
	output rv_core_pkg::br_cond_e  br_cond_o,
	output logic                   jalr_o,
	output logic                   mem_we_o,
	output logic                   invalid_o,
	output logic                   stop_o
);

	import rv_core_pkg::*;

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i_type;
	logic [`RV_XLEN-1:0] imm_s_type;
	logic [`RV_XLEN-1:0] imm_b_type;
	logic [`RV_XLEN-1:0] imm_u_type;
	logic [`RV_XLEN-1:0] imm_j_type;
	logic                rd_we;
	logic                mem_we;
	logic                ebreak;

	// alt selects sub or sra where funct3 allows it
	function automatic alu_op_e alu_for(logic [2:0] f3, logic alt);
		case (f3)
			`RV_F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			`RV_F3_SLL:  return ALU_SLL;
			`RV_F3_SLT:  return ALU_SLT;
			`RV_F3_SLTU: return ALU_SLTU;
			`RV_F3_XOR:  return ALU_XOR;
			`RV_F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			`RV_F3_OR:   return ALU_OR;
			default:     return ALU_AND;
		endcase
	endfunction

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rs1_o  = inst_i[19:15];
	assign rs2_o  = inst_i[24:20];
	assign rd_o   = inst_i[11:7];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_u_type = {inst_i[31:12], 12'd0};
	assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	assign ebreak = (inst_i == `RV_EBREAK);

	always_comb begin
		imm_o       = imm_i_type;
		alu_op_o    = ALU_ADD;
		src_a_pc_o  = 1'b0;
		src_b_imm_o = 1'b0;
		wb_sel_o    = WB_ALU;
		br_cond_o   = BR_NONE;
		jalr_o      = 1'b0;
		rd_we       = 1'b0;
		mem_we      = 1'b0;
		invalid_o   = 1'b0;
		case (opcode)
			`RV_OP_LUI: begin
				imm_o       = imm_u_type;
				alu_op_o    = ALU_PASS_B;
				src_b_imm_o = 1'b1;
				rd_we       = 1'b1;
			end
			`RV_OP_AUIPC: begin
				imm_o       = imm_u_type;
				src_a_pc_o  = 1'b1;
				src_b_imm_o = 1'b1;
				rd_we       = 1'b1;
			end
			`RV_OP_JAL: begin
				imm_o     = imm_j_type;
				wb_sel_o  = WB_LINK;
				br_cond_o = BR_JUMP;
				rd_we     = 1'b1;
			end
			`RV_OP_JALR: begin
				wb_sel_o  = WB_LINK;
				br_cond_o = BR_JUMP;
				jalr_o    = 1'b1;
				rd_we     = 1'b1;
				invalid_o = (funct3 != `RV_F3_JALR);
			end
			`RV_OP_BRANCH: begin
				imm_o = imm_b_type;
				case (funct3)
					`RV_F3_BEQ:  br_cond_o = BR_EQ;
					`RV_F3_BNE:  br_cond_o = BR_NE;
					`RV_F3_BLT:  br_cond_o = BR_LT;
					`RV_F3_BGE:  br_cond_o = BR_GE;
					`RV_F3_BLTU: br_cond_o = BR_LTU;
					`RV_F3_BGEU: br_cond_o = BR_GEU;
					default:     invalid_o = 1'b1;
				endcase
			end
			`RV_OP_LOAD: begin
				src_b_imm_o = 1'b1;
				wb_sel_o    = WB_LOAD;
				rd_we       = 1'b1;
				invalid_o   = (funct3 != `RV_F3_WORD);
			end
			`RV_OP_STORE: begin
				imm_o       = imm_s_type;
				src_b_imm_o = 1'b1;
				mem_we      = 1'b1;
				invalid_o   = (funct3 != `RV_F3_WORD);
			end
			`RV_OP_IMM: begin
				src_b_imm_o = 1'b1;
				rd_we       = 1'b1;
				// addi has no subtract form, only srai uses the alt bit
				alu_op_o    = alu_for(funct3, (funct3 == `RV_F3_SR) && (funct7 == `RV_F7_ALT));
				if (funct3 == `RV_F3_SLL)
					invalid_o = (funct7 != `RV_F7_BASE);
				else if (funct3 == `RV_F3_SR)
					invalid_o = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
			end
			`RV_OP_REG: begin
				rd_we     = 1'b1;
				alu_op_o  = alu_for(funct3, funct7 == `RV_F7_ALT);
				invalid_o = !((funct7 == `RV_F7_BASE) || ((funct7 == `RV_F7_ALT)
					&& (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR)));
			end
			`RV_OP_SYSTEM: begin
				// ebreak is the only system word
				invalid_o = !ebreak;
			end
			default: begin
				invalid_o = 1'b1;
			end
		endcase
	end

	assign stop_o = invalid_o || ebreak;

	// no side effects from a stop instruction, in reset or once halted
	assign rd_we_o  = rd_we && !(stop_o || halted_i);
	assign mem_we_o = mem_we && !(stop_o || halted_i);

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_execute (
	input  logic [`RV_XLEN-1:0]   pc_i,
	input  logic [`RV_XLEN-1:0]   rs1_data_i,
	input  logic [`RV_XLEN-1:0]   rs2_data_i,
	input  logic [`RV_XLEN-1:0]   imm_i,
	input  rv_core_pkg::alu_op_e  alu_op_i,
	input  logic                  src_a_pc_i,
	input  logic                  src_b_imm_i,
	input  rv_core_pkg::wb_sel_e  wb_sel_i,
	input  rv_core_pkg::br_cond_e br_cond_i,
	input  logic                  jalr_i,
	input  logic                  mem_we_i,
	input  logic [`RV_XLEN-1:0]   dmem_rdata_i,
	output logic [`RV_XLEN-1:0]   dmem_addr_o,
	output logic                  dmem_we_o,
	output logic [`RV_XLEN-1:0]   dmem_wdata_o,
	output logic                  redirect_o,
	output logic [`RV_XLEN-1:0]   target_o,
	output logic [`RV_XLEN-1:0]   wb_data_o
);

	import rv_core_pkg::*;

	logic [`RV_XLEN-1:0] src_a;
	logic [`RV_XLEN-1:0] src_b;
	logic [`RV_XLEN-1:0] alu_res;
	logic [`RV_XLEN-1:0] pc_plus_4;
	logic [`RV_XLEN-1:0] jalr_sum;
	logic [4:0]          shamt;

	assign src_a = src_a_pc_i ? pc_i : rs1_data_i;
	assign src_b = src_b_imm_i ? imm_i : rs2_data_i;
	assign shamt = src_b[4:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    alu_res = src_a + src_b;
			ALU_SUB:    alu_res = src_a - src_b;
			ALU_SLL:    alu_res = src_a << shamt;
			ALU_SLT:    alu_res = {31'b0, $signed(src_a) < $signed(src_b)};
			ALU_SLTU:   alu_res = {31'b0, src_a < src_b};
			ALU_XOR:    alu_res = src_a ^ src_b;
			ALU_SRL:    alu_res = src_a >> shamt;
			ALU_SRA:    alu_res = $unsigned($signed(src_a) >>> shamt);
			ALU_OR:     alu_res = src_a | src_b;
			ALU_AND:    alu_res = src_a & src_b;
			ALU_PASS_B: alu_res = src_b;
			default:    alu_res = src_a + src_b;
		endcase
	end

	// branch compare always uses the register operands
	always_comb begin
		case (br_cond_i)
			BR_EQ:   redirect_o = (rs1_data_i == rs2_data_i);
			BR_NE:   redirect_o = (rs1_data_i != rs2_data_i);
			BR_LT:   redirect_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
			BR_GE:   redirect_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
			BR_LTU:  redirect_o = (rs1_data_i < rs2_data_i);
			BR_GEU:  redirect_o = (rs1_data_i >= rs2_data_i);
			BR_JUMP: redirect_o = 1'b1;
			default: redirect_o = 1'b0;
		endcase
	end

	assign pc_plus_4 = pc_i + `RV_XLEN'd4;
	assign jalr_sum  = rs1_data_i + imm_i;
	// jalr drops bit 0 of the sum
	assign target_o  = jalr_i ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc_i + imm_i;

	assign dmem_addr_o  = alu_res;
	assign dmem_we_o    = mem_we_i;
	assign dmem_wdata_o = rs2_data_i;

	always_comb begin
		case (wb_sel_i)
			WB_LOAD: wb_data_o = dmem_rdata_i;
			WB_LINK: wb_data_o = pc_plus_4;
			default: wb_data_o = alu_res;
		endcase
	end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_top (
	input  logic                clk,
	input  logic                rst,
	output logic [`RV_XLEN-1:0] imem_addr_o,
	input  logic [`RV_XLEN-1:0] imem_data_i,
	output logic [`RV_XLEN-1:0] dmem_addr_o,
	output logic                dmem_we_o,
	output logic [`RV_XLEN-1:0] dmem_wdata_o,
	input  logic [`RV_XLEN-1:0] dmem_rdata_i,
	output logic                wb_en_o,
	output logic [4:0]          wb_addr_o,
	output logic [`RV_XLEN-1:0] wb_data_o,
	output logic                invalid_o,
	output logic                halt_o
);

	import rv_core_pkg::*;

	logic [`RV_XLEN-1:0] pc;
	logic                halt;
	logic                hold;
	logic                stop;
	logic                redirect;
	logic [`RV_XLEN-1:0] target;

	logic [4:0]          rs1;
	logic [4:0]          rs2;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] imm;
	alu_op_e             alu_op;
	wb_sel_e             wb_sel;
	br_cond_e            br_cond;
	logic                src_a_pc;
	logic                src_b_imm;
	logic                jalr;
	logic                mem_we;
	logic                rd_we;
	logic [4:0]          rd;
	logic [`RV_XLEN-1:0] wb_data;

	// no commits while reset is held or after a stop
	assign hold = halt | ~rst;

	rv_pc_counter u_pc_counter (
		.clk        (clk),
		.rst        (rst),
		.redirect_i (redirect),
		.target_i   (target),
		.stop_i     (stop),
		.pc_o       (pc),
		.halt_o     (halt)
	);

	rv_decoder u_decoder (
		.inst_i      (imem_data_i),
		.halted_i    (hold),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.imm_o       (imm),
		.alu_op_o    (alu_op),
		.src_a_pc_o  (src_a_pc),
		.src_b_imm_o (src_b_imm),
		.wb_sel_o    (wb_sel),
		.rd_we_o     (rd_we),
		.rd_o        (rd),
		.br_cond_o   (br_cond),
		.jalr_o      (jalr),
		.mem_we_o    (mem_we),
		.invalid_o   (invalid_o),
		.stop_o      (stop)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.we_i     (rd_we),
		.waddr_i  (rd),
		.wdata_i  (wb_data),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	rv_execute u_execute (
		.pc_i         (pc),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.imm_i        (imm),
		.alu_op_i     (alu_op),
		.src_a_pc_i   (src_a_pc),
		.src_b_imm_i  (src_b_imm),
		.wb_sel_i     (wb_sel),
		.br_cond_i    (br_cond),
		.jalr_i       (jalr),
		.mem_we_i     (mem_we),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_wdata_o (dmem_wdata_o),
		.redirect_o   (redirect),
		.target_o     (target),
		.wb_data_o    (wb_data)
	);

	// commit trace mirrors the register file write port
	assign imem_addr_o = pc;
	assign wb_en_o     = rd_we;
	assign wb_addr_o   = rd;
	assign wb_data_o   = wb_data;
	assign halt_o      = halt;

endmodule

// File: verification/rv_core_assertions.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_assertions (
	input logic                clk,
	input logic                rst,
	input logic                halt_i,
	input logic                dmem_we_i,
	input logic                wb_en_i,
	input logic [`RV_XLEN-1:0] imem_addr_i
);

	int fail_count = 0;

	// halted core writes nothing
	no_write_halted: assert property (@(posedge clk) disable iff (!rst)
		halt_i |-> (!dmem_we_i && !wb_en_i))
	else begin
		fail_count++;
		$error("register or memory write while halted");
	end

	no_pc_move_halted: assert property (@(posedge clk) disable iff (!rst)
		halt_i |-> $stable(imem_addr_i))
	else begin
		fail_count++;
		$error("pc changed while halted");
	end

	fetch_aligned: assert property (@(posedge clk) disable iff (!rst)
		imem_addr_i[1:0] == 2'b00)
	else begin
		fail_count++;
		$error("fetch address not word aligned");
	end

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_tb;

	localparam int PROG_LEN    = 120;
	localparam int RUN_LIMIT   = 2000;
	localparam int RESET_LIMIT = 16;

	logic                clk;
	logic                rst;
	logic [`RV_XLEN-1:0] imem_addr;
	logic [`RV_XLEN-1:0] imem_data;
	logic [`RV_XLEN-1:0] dmem_addr;
	logic                dmem_we;
	logic [`RV_XLEN-1:0] dmem_wdata;
	logic [`RV_XLEN-1:0] dmem_rdata;
	logic                wb_en;
	logic [4:0]          wb_addr;
	logic [`RV_XLEN-1:0] wb_data;
	logic                invalid;
	logic                halt;

	logic [`RV_XLEN-1:0] imem [0:255];
	logic [`RV_XLEN-1:0] dmem [0:63];

	// reference model state, plus registers rebuilt from the commit trace
	logic [`RV_XLEN-1:0] mregs [0:31];
	logic [`RV_XLEN-1:0] mdmem [0:63];
	logic [`RV_XLEN-1:0] trace_regs [0:31];
	logic [`RV_XLEN-1:0] mpc;
	logic                m_halted;
	logic                m_invalid;
	int                  errors;
	int                  checks;

	rv_core_top rv_core_top_i (
		.clk          (clk),
		.rst          (rst),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_addr_o  (dmem_addr),
		.dmem_we_o    (dmem_we),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata),
		.wb_en_o      (wb_en),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data),
		.invalid_o    (invalid),
		.halt_o       (halt)
	);

	bind rv_core_top rv_core_assertions u_assertions (
		.clk         (clk),
		.rst         (rst),
		.halt_i      (halt_o),
		.dmem_we_i   (dmem_we_o),
		.wb_en_i     (wb_en_o),
		.imem_addr_i (imem_addr_o)
	);

	always #50 clk = ~clk;

	// both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	task automatic report_mismatch(string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] alu_model(logic [2:0] f3, logic [6:0] f7,
			logic [31:0] a, logic [31:0] b, bit is_imm);
		case (f3)
			`RV_F3_ADD:  return (!is_imm && f7 == `RV_F7_ALT) ? a - b : a + b;
			`RV_F3_SLL:  return a << b[4:0];
			`RV_F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
			`RV_F3_SLTU: return {31'd0, a < b};
			`RV_F3_XOR:  return a ^ b;
			`RV_F3_SR:   return (f7 == `RV_F7_ALT) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			`RV_F3_OR:   return a | b;
			default:     return a & b;
		endcase
	endfunction

	function automatic bit branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			`RV_F3_BEQ:  return a == b;
			`RV_F3_BNE:  return a != b;
			`RV_F3_BLT:  return $signed(a) < $signed(b);
			`RV_F3_BGE:  return $signed(a) >= $signed(b);
			`RV_F3_BLTU: return a < b;
			`RV_F3_BGEU: return a >= b;
			default:     return 1'b0;
		endcase
	endfunction

	// random legal instruction; control flow only jumps forward by 4 to 32 bytes
	function automatic logic [31:0] gen_inst(int idx, bit allow_ctrl);
		int          kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] r;
		logic [20:0] off;
		logic [11:0] imm;
		kind = allow_ctrl ? $urandom_range(0, 9) : $urandom_range(0, 5);
		rd   = 5'($urandom_range(0, 31));
		rs1  = 5'($urandom_range(0, 31));
		rs2  = 5'($urandom_range(0, 31));
		r    = $urandom;
		off  = 21'(4 * $urandom_range(1, 8));
		imm  = 12'(4 * $urandom_range(0, 63));
		f3   = r[2:0];
		case (kind)
			0: return {r[31:12], rd, `RV_OP_LUI};
			1: return {r[31:12], rd, `RV_OP_AUIPC};
			2: begin
				if (f3 == `RV_F3_SLL)
					return {`RV_F7_BASE, r[24:20], rs1, f3, rd, `RV_OP_IMM};
				if (f3 == `RV_F3_SR)
					return {(r[3] ? `RV_F7_ALT : `RV_F7_BASE), r[24:20], rs1, f3, rd, `RV_OP_IMM};
				return {r[31:20], rs1, f3, rd, `RV_OP_IMM};
			end
			4: return {imm, 5'd0, `RV_F3_WORD, rd, `RV_OP_LOAD};
			5: return {imm[11:5], rs2, 5'd0, `RV_F3_WORD, imm[4:0], `RV_OP_STORE};
			6: begin
				// funct3 2 and 3 are not branches, fold them onto beq and bne
				if (f3[2:1] == 2'b01)
					f3[1] = 1'b0;
				return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
			end
			7: return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
			8: begin
				// x0 base, so the immediate is the absolute target
				imm = 12'(idx * 4) + off[11:0];
				return {imm, 5'd0, `RV_F3_JALR, rd, `RV_OP_JALR};
			end
			default: begin
				f7 = (r[3] && (f3 == `RV_F3_ADD || f3 == `RV_F3_SR)) ? `RV_F7_ALT : `RV_F7_BASE;
				return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
			end
		endcase
	endfunction

	task automatic load_program(bit with_invalid);
		int          inv_idx;
		logic [31:0] r;
		inv_idx = PROG_LEN / 2;
		for (int i = 0; i < 256; i++)
			imem[i] = `RV_EBREAK;
		// no control flow just ahead of the invalid word, so it is always reached
		for (int i = 0; i < PROG_LEN; i++)
			imem[i] = gen_inst(i, !(with_invalid && i >= inv_idx - 8 && i < inv_idx));
		if (with_invalid) begin
			r = $urandom;
			imem[inv_idx] = {r[31:7], 7'b1111111};
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i]  = $urandom;
			mdmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			mregs[i]      = '0;
			trace_regs[i] = '0;
		end
		mpc       = `RV_RESET_PC;
		m_halted  = 1'b0;
		m_invalid = 1'b0;
	endtask

	task automatic apply_reset();
		int cyc;
		cyc = 0;
		@(posedge clk);
		#1 rst = 1'b0;
		fork
			begin
				repeat (8) @(posedge clk);
				#1 rst = 1'b1;
			end
			while (!rst && cyc < RESET_LIMIT) begin
				@(negedge clk);
				if (!rst && (wb_en !== 1'b0 || dmem_we !== 1'b0))
					report_mismatch("write strobe high during reset");
				cyc++;
			end
		join
		if (!rst) begin
			errors++;
			$display("reset release not seen within %0d cycles", RESET_LIMIT);
		end
		checks++;
		if (imem_addr !== `RV_RESET_PC || halt !== 1'b0)
			report_mismatch($sformatf("after reset pc %h halt %b", imem_addr, halt));
	endtask

	// one model step at mid-cycle, compared with the commit of the DUT
	task automatic check_cycle();
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] ld_addr;
		logic [31:0] st_addr;
		logic [31:0] exp_data;
		logic [31:0] npc;
		logic [6:0]  op;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic        exp_we;
		logic        exp_mwe;
		logic        inv;
		logic        stop;
		inst    = imem[mpc[9:2]];
		op      = inst[6:0];
		rd      = inst[11:7];
		f3      = inst[14:12];
		a       = mregs[inst[19:15]];
		b       = mregs[inst[24:20]];
		imm_i   = {{20{inst[31]}}, inst[31:20]};
		imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u   = {inst[31:12], 12'd0};
		imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		ld_addr = a + imm_i;
		st_addr = a + imm_s;
		case (op)
			`RV_OP_LUI:             exp_data = imm_u;
			`RV_OP_AUIPC:           exp_data = mpc + imm_u;
			`RV_OP_JAL, `RV_OP_JALR: exp_data = mpc + 32'd4;
			`RV_OP_LOAD:            exp_data = mdmem[ld_addr[7:2]];
			`RV_OP_IMM:             exp_data = alu_model(f3, inst[31:25], a, imm_i, 1'b1);
			`RV_OP_REG:             exp_data = alu_model(f3, inst[31:25], a, b, 1'b0);
			default:                exp_data = '0;
		endcase
		case (op)
			`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_IMM, `RV_OP_REG: inv = 1'b0;
			`RV_OP_JALR:              inv = (f3 != `RV_F3_JALR);
			`RV_OP_BRANCH:            inv = (f3[2:1] == 2'b01);
			`RV_OP_LOAD, `RV_OP_STORE: inv = (f3 != `RV_F3_WORD);
			default:                  inv = (inst != `RV_EBREAK);
		endcase
		exp_we  = op inside {`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR,
			`RV_OP_LOAD, `RV_OP_IMM, `RV_OP_REG};
		exp_mwe = (op == `RV_OP_STORE);
		npc     = mpc + 32'd4;
		if (op == `RV_OP_JAL)
			npc = mpc + imm_j;
		if (op == `RV_OP_JALR)
			npc = (a + imm_i) & ~32'd1;
		if (op == `RV_OP_BRANCH && branch_taken(f3, a, b))
			npc = mpc + imm_b;
		stop = inv || (inst == `RV_EBREAK);
		if (stop) begin
			exp_we  = 1'b0;
			exp_mwe = 1'b0;
			npc     = mpc;
		end

		checks++;
		if (imem_addr !== mpc)
			report_mismatch($sformatf("pc %h, expected %h", imem_addr, mpc));
		if (invalid !== inv)
			report_mismatch($sformatf("invalid_o %b at pc %h, expected %b", invalid, mpc, inv));
		if (!exp_we && wb_en !== 1'b0)
			report_mismatch($sformatf("register write at pc %h, none expected", mpc));
		// a write to x0 may show on the trace but has no effect
		if (exp_we && rd != 5'd0 && (wb_en !== 1'b1 || wb_addr !== rd || wb_data !== exp_data))
			report_mismatch($sformatf("commit x%0d=%h en %b, expected x%0d=%h",
				wb_addr, wb_data, wb_en, rd, exp_data));
		if (dmem_we !== exp_mwe)
			report_mismatch($sformatf("dmem_we_o %b at pc %h, expected %b", dmem_we, mpc, exp_mwe));
		if (exp_mwe && (dmem_addr !== st_addr || dmem_wdata !== b))
			report_mismatch($sformatf("store [%h]=%h, expected [%h]=%h",
				dmem_addr, dmem_wdata, st_addr, b));

		if (wb_en === 1'b1 && wb_addr != 5'd0)
			trace_regs[wb_addr] = wb_data;
		if (exp_we && rd != 5'd0)
			mregs[rd] = exp_data;
		if (exp_mwe)
			mdmem[st_addr[7:2]] = b;
		mpc       = npc;
		m_halted  = stop;
		m_invalid = inv;
	endtask

	task automatic run_program(bit with_invalid);
		int cyc;
		cyc = 0;
		while (halt !== 1'b1 && cyc < RUN_LIMIT) begin
			if (m_halted) begin
				report_mismatch("halt_o low one cycle after the stop instruction");
				break;
			end
			check_cycle();
			cyc++;
			@(negedge clk);
		end
		if (halt !== 1'b1 && !m_halted) begin
			errors++;
			$display("run timed out, halt_o did not rise within %0d cycles", RUN_LIMIT);
		end else if (!m_halted) begin
			report_mismatch("halt_o rose before the stop instruction");
		end
		// core must stay frozen once halted
		for (int k = 0; k < 4; k++) begin
			checks++;
			if (imem_addr !== mpc || wb_en !== 1'b0 || dmem_we !== 1'b0 || halt !== 1'b1
					|| invalid !== m_invalid)
				report_mismatch($sformatf("halted state moved, pc %h expected %h", imem_addr, mpc));
			@(negedge clk);
		end
		if (with_invalid && !m_invalid)
			report_mismatch("invalid word was never reached");
		if (!with_invalid && m_invalid)
			report_mismatch("normal run stopped on an invalid word");
		for (int i = 1; i < 32; i++) begin
			if (trace_regs[i] !== mregs[i])
				report_mismatch($sformatf("final x%0d %h, expected %h", i, trace_regs[i], mregs[i]));
		end
		for (int i = 0; i < 64; i++) begin
			if (dmem[i] !== mdmem[i])
				report_mismatch($sformatf("final dmem[%0d] %h, expected %h", i, dmem[i], mdmem[i]));
		end
	endtask

	initial begin
		clk    = 1'b0;
		rst    = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(32'h1758f01e));
		load_program(1'b0);
		apply_reset();
		run_program(1'b0);
		load_program(1'b1);
		apply_reset();
		run_program(1'b1);
		errors += rv_core_top_i.u_assertions.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_pc_counter.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := rv_core_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
SIM_FLAGS := +verilator+error+limit+1000

SIM  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_FLAGS))"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
